//--- hw/lstm_pkg.sv
`default_nettype none

package lstm_pkg;

  //////////////////////////////////////////////////////////////
  // fixed point format, Q8.16 data
  localparam int QZ_R   = 8;             // integer bits
  localparam int QZ_D   = 16;            // fraction bits
  localparam int QZ     = QZ_R + QZ_D;   // data word
  localparam int BIAS_W = 16;            // bias is Q0.16
  localparam int ACC_W  = 56;            // 48b product + 8b headroom

  localparam int GATE_NUM    = 4;
  localparam int GATE_IN     = 0;        // lowest slot in every four-gate word
  localparam int GATE_FORGET = 1;
  localparam int GATE_CELL   = 2;
  localparam int GATE_OUT    = 3;

  localparam logic signed [QZ-1:0] ONE_Q = QZ'(1 << QZ_D);  // 1.0

  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,
    PH_INPUT = 2'd1,                     // weights x features
    PH_RECUR = 2'd2,                     // weights x previous h
    PH_WAIT  = 2'd3                      // drain until last h write
  } phase_t;

  // Q.32 accumulator back to Q8.16, clipped to the data range
  function automatic logic [QZ-1:0] sat_q(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] s;
    s = v >>> QZ_D;                      // arithmetic, keeps sign
    if (&s[ACC_W-1:QZ-1] || ~|s[ACC_W-1:QZ-1])
      return s[QZ-1:0];                  // fits
    return s[ACC_W-1] ? {1'b1, {(QZ-1){1'b0}}} : {1'b0, {(QZ-1){1'b1}}};
  endfunction

endpackage

`default_nettype wire

//--- hw/lstm_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lstm_seq_ctrl #(
  parameter  int INPUT_SIZE  = 4,
  parameter  int HIDDEN_SIZE = 4,
  parameter  int SEQ_LEN     = 3,
  localparam int IW          = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start_i,
  input  logic             weight_valid_i,
  input  logic             h_wr_en_i,
  input  logic [IW-1:0]    h_wr_addr_i,
  output lstm_pkg::phase_t phase_o,
  output logic             beat_valid_o,
  output logic             first_beat_o,
  output logic             last_beat_o,
  output logic [IW-1:0]    h_rd_addr_o,
  output logic [IW-1:0]    unit_index_o,
  output logic             bank_sel_o,
  output logic             seq_first_o,
  output logic             x_read_o,
  output logic             step_done_o
);

  localparam int MAX_BEAT = (INPUT_SIZE > HIDDEN_SIZE) ? INPUT_SIZE : HIDDEN_SIZE;
  localparam int BW       = (MAX_BEAT > 1) ? $clog2(MAX_BEAT) : 1;
  localparam int SW       = (SEQ_LEN > 1) ? $clog2(SEQ_LEN) : 1;

  lstm_pkg::phase_t phase_q;
  logic [BW-1:0]    beat_cnt;            // feature / h index inside a phase
  logic [IW-1:0]    unit_cnt;            // hidden unit being accumulated
  logic [SW-1:0]    seq_cnt;             // step inside the sequence
  logic             in_last;
  logic             rec_last;
  logic             unit_last;

  assign in_last   = (beat_cnt == BW'(INPUT_SIZE - 1));
  assign rec_last  = (beat_cnt == BW'(HIDDEN_SIZE - 1));
  assign unit_last = (unit_cnt == IW'(HIDDEN_SIZE - 1));

  assign beat_valid_o = weight_valid_i
                      && (phase_q == lstm_pkg::PH_INPUT || phase_q == lstm_pkg::PH_RECUR);
  assign first_beat_o = (phase_q == lstm_pkg::PH_INPUT) && (beat_cnt == '0);
  assign last_beat_o  = (phase_q == lstm_pkg::PH_RECUR) && rec_last;
  assign x_read_o     = beat_valid_o && (phase_q == lstm_pkg::PH_INPUT);
  assign h_rd_addr_o  = beat_cnt[IW-1:0];  // only meaningful in PH_RECUR
  assign phase_o      = phase_q;
  assign seq_first_o  = (seq_cnt == '0);   // zero h and c on the first step
  assign step_done_o  = (phase_q == lstm_pkg::PH_WAIT) && h_wr_en_i
                      && (h_wr_addr_i == IW'(HIDDEN_SIZE - 1));

  //////////////////////////////////////////////////////////////
  // step / unit / beat sequencing
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase_q      <= lstm_pkg::PH_IDLE;
      beat_cnt     <= '0;
      unit_cnt     <= '0;
      unit_index_o <= '0;
      seq_cnt      <= '0;
      bank_sel_o   <= 1'b0;
    end
    else
    begin
      unique case (phase_q)
        lstm_pkg::PH_IDLE:
        begin
          beat_cnt <= '0;
          unit_cnt <= '0;
          if (start_i)
            phase_q <= lstm_pkg::PH_INPUT;
        end
        lstm_pkg::PH_INPUT:
        begin
          if (beat_valid_o)
          begin
            beat_cnt <= in_last ? '0 : beat_cnt + 1'b1;
            if (in_last)
              phase_q <= lstm_pkg::PH_RECUR;
          end
        end
        lstm_pkg::PH_RECUR:
        begin
          if (beat_valid_o)
          begin
            beat_cnt <= rec_last ? '0 : beat_cnt + 1'b1;
            if (rec_last)
            begin
              unit_index_o <= unit_cnt;  // travels with gates_valid
              unit_cnt     <= unit_last ? '0 : unit_cnt + 1'b1;
              phase_q      <= unit_last ? lstm_pkg::PH_WAIT : lstm_pkg::PH_INPUT;
            end
          end
        end
        lstm_pkg::PH_WAIT:
        begin
          if (step_done_o)
          begin
            phase_q    <= lstm_pkg::PH_IDLE;
            bank_sel_o <= !bank_sel_o;   // new h becomes the read bank
            seq_cnt    <= (seq_cnt == SW'(SEQ_LEN - 1)) ? '0 : seq_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // stream protocol, no beats outside a step and no restart inside one
  assert property (@(posedge clk) disable iff (!rst_n)
    (phase_q == lstm_pkg::PH_IDLE) |-> !weight_valid_i);
  assert property (@(posedge clk) disable iff (!rst_n)
    (phase_q != lstm_pkg::PH_IDLE) |-> !start_i);

endmodule

`default_nettype wire

//--- hw/gate_mac.sv
`timescale 1ns/1ps
`default_nettype none

module gate_mac (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  lstm_pkg::phase_t                               phase_i,
  input  logic                                           beat_valid_i,
  input  logic                                           first_beat_i,
  input  logic                                           last_beat_i,
  input  logic [lstm_pkg::GATE_NUM*lstm_pkg::QZ-1:0]     weight_i,
  input  logic [lstm_pkg::QZ-1:0]                        x_i,
  input  logic [lstm_pkg::QZ-1:0]                        h_prev_i,
  input  logic [lstm_pkg::GATE_NUM*lstm_pkg::BIAS_W-1:0] bias_i,
  output logic [lstm_pkg::GATE_NUM*lstm_pkg::QZ-1:0]     gates_pre_o,
  output logic                                           gates_valid_o
);

  localparam int QZ       = lstm_pkg::QZ;
  localparam int QZ_D     = lstm_pkg::QZ_D;
  localparam int BIAS_W   = lstm_pkg::BIAS_W;
  localparam int ACC_W    = lstm_pkg::ACC_W;
  localparam int GATE_NUM = lstm_pkg::GATE_NUM;

  logic signed [QZ-1:0]    operand;
  logic signed [2*QZ-1:0]  prod     [GATE_NUM];
  logic signed [ACC_W-1:0] base     [GATE_NUM];
  logic signed [ACC_W-1:0] acc_nxt  [GATE_NUM];
  logic signed [ACC_W-1:0] bias_ext [GATE_NUM];
  logic signed [ACC_W-1:0] total    [GATE_NUM];
  logic signed [ACC_W-1:0] acc_q    [GATE_NUM];
  logic                    done_beat;

  assign operand   = (phase_i == lstm_pkg::PH_INPUT) ? x_i : h_prev_i;  // x first, then h
  assign done_beat = beat_valid_i && last_beat_i;

  //////////////////////////////////////////////////////////////
  // four gates side by side
  always_comb
  begin
    for (int g = 0; g < GATE_NUM; g++)
    begin
      prod[g]    = $signed(weight_i[g*QZ +: QZ]) * operand;         // Q16.32
      base[g]    = first_beat_i ? '0 : acc_q[g];                    // restart per unit
      acc_nxt[g] = base[g] + {{(ACC_W-2*QZ){prod[g][2*QZ-1]}}, prod[g]};
      // Q0.16 bias moved up to the Q.32 point of the products
      bias_ext[g] = {{(ACC_W-BIAS_W-QZ_D){bias_i[g*BIAS_W+BIAS_W-1]}},
                     bias_i[g*BIAS_W +: BIAS_W], {QZ_D{1'b0}}};
      total[g]    = acc_nxt[g] + bias_ext[g];
    end
  end

  always_ff @(posedge clk)
  begin
    if (beat_valid_i)
    begin
      for (int g = 0; g < GATE_NUM; g++)
        acc_q[g] <= acc_nxt[g];
    end
  end

  // bias add, rescale and clip land together with the last product
  always_ff @(posedge clk)
  begin
    if (done_beat)
    begin
      for (int g = 0; g < GATE_NUM; g++)
        gates_pre_o[g*QZ +: QZ] <= lstm_pkg::sat_q(total[g]);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      gates_valid_o <= 1'b0;
    else
      gates_valid_o <= done_beat;        // one cycle after last_beat
  end

endmodule

`default_nettype wire

//--- hw/cell_update.sv
`timescale 1ns/1ps
`default_nettype none

module cell_update #(
  parameter  int HIDDEN_SIZE = 4,
  localparam int IW          = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic [lstm_pkg::GATE_NUM*lstm_pkg::QZ-1:0] gates_pre_i,
  input  logic                                       gates_valid_i,
  input  logic [IW-1:0]                              unit_index_i,
  input  logic [lstm_pkg::QZ-1:0]                    c_prev_i,
  output logic [IW-1:0]                              c_rd_addr_o,
  output logic                                       c_wr_en_o,
  output logic [lstm_pkg::QZ-1:0]                    c_wr_data_o,
  output logic                                       h_wr_en_o,
  output logic [IW-1:0]                              h_wr_addr_o,
  output logic [lstm_pkg::QZ-1:0]                    h_wr_data_o,
  output logic [lstm_pkg::QZ-1:0]                    h_o,
  output logic [IW-1:0]                              h_index_o,
  output logic                                       h_valid_o
);

  localparam int QZ    = lstm_pkg::QZ;
  localparam int ACC_W = lstm_pkg::ACC_W;

  // x/4 + 0.5 clipped to [0, 1]
  function automatic logic signed [QZ-1:0] hard_sigmoid(input logic signed [QZ-1:0] x);
    logic signed [QZ-1:0] y;
    y = (x >>> 2) + (lstm_pkg::ONE_Q >>> 1);
    if (y < 0)
      y = '0;
    else if (y > lstm_pkg::ONE_Q)
      y = lstm_pkg::ONE_Q;
    return y;
  endfunction

  function automatic logic signed [QZ-1:0] hard_tanh(input logic signed [QZ-1:0] x);
    if (x > lstm_pkg::ONE_Q)
      return lstm_pkg::ONE_Q;
    if (x < -lstm_pkg::ONE_Q)
      return -lstm_pkg::ONE_Q;
    return x;
  endfunction

  logic                    s1_valid;
  logic [IW-1:0]           s1_idx;
  logic signed [QZ-1:0]    s1_i, s1_f, s1_g, s1_o, s1_c;
  logic [IW-1:0]           s2_idx;     // also the cell write address
  logic signed [QZ-1:0]    s2_o;
  logic signed [2*QZ-1:0]  fc_prod, ig_prod, oh_prod;
  logic signed [ACC_W-1:0] c_sum;
  logic signed [QZ-1:0]    c_tanh;

  // single address port on the cell bank where the stage 2 write wins
  assign c_rd_addr_o = c_wr_en_o ? s2_idx : unit_index_i;

  //////////////////////////////////////////////////////////////
  // stage 1 with activations and c_prev capture
  always_ff @(posedge clk)
  begin
    if (gates_valid_i)
    begin
      s1_i <= hard_sigmoid($signed(gates_pre_i[lstm_pkg::GATE_IN*QZ +: QZ]));
      s1_f <= hard_sigmoid($signed(gates_pre_i[lstm_pkg::GATE_FORGET*QZ +: QZ]));
      s1_g <= hard_tanh($signed(gates_pre_i[lstm_pkg::GATE_CELL*QZ +: QZ]));
      s1_o <= hard_sigmoid($signed(gates_pre_i[lstm_pkg::GATE_OUT*QZ +: QZ]));
      s1_c <= c_prev_i;                  // already zero on a first step
    end
  end

  // stage 2 computes c = f*c_prev + i*g
  assign fc_prod = s1_f * s1_c;
  assign ig_prod = s1_i * s1_g;
  assign c_sum   = {{(ACC_W-2*QZ){fc_prod[2*QZ-1]}}, fc_prod}
                 + {{(ACC_W-2*QZ){ig_prod[2*QZ-1]}}, ig_prod};

  always_ff @(posedge clk)
  begin
    if (s1_valid)
    begin
      c_wr_data_o <= lstm_pkg::sat_q(c_sum);
      s2_o        <= s1_o;
    end
  end

  // stage 3 computes h = o * hardtanh(c)
  assign c_tanh  = hard_tanh(c_wr_data_o);
  assign oh_prod = s2_o * c_tanh;       // |o*tanh| <= 1 so the clip never hits

  always_ff @(posedge clk)
  begin
    if (c_wr_en_o)
      h_o <= lstm_pkg::sat_q({{(ACC_W-2*QZ){oh_prod[2*QZ-1]}}, oh_prod});
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_valid  <= 1'b0;
      s1_idx    <= '0;
      c_wr_en_o <= 1'b0;
      s2_idx    <= '0;
      h_valid_o <= 1'b0;
      h_index_o <= '0;
    end
    else
    begin
      s1_valid  <= gates_valid_i;
      s1_idx    <= unit_index_i;
      c_wr_en_o <= s1_valid;
      s2_idx    <= s1_idx;
      h_valid_o <= c_wr_en_o;
      h_index_o <= s2_idx;
    end
  end

  assign h_wr_en_o   = h_valid_o;
  assign h_wr_addr_o = h_index_o;
  assign h_wr_data_o = h_o;

  // later stages carry this index unchanged
  assert property (@(posedge clk) disable iff (!rst_n)
    s1_valid |-> (s1_idx < HIDDEN_SIZE));
  // units must be spaced so the c read never meets a pending c write
  assert property (@(posedge clk) disable iff (!rst_n)
    gates_valid_i |-> !c_wr_en_o);

endmodule

`default_nettype wire

//--- hw/state_ram.sv
`timescale 1ns/1ps
`default_nettype none

module state_ram #(
  parameter  int HIDDEN_SIZE = 4,
  localparam int IW          = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    bank_sel_i,
  input  logic                    seq_first_i,
  input  logic [IW-1:0]           h_rd_addr_i,
  input  logic [IW-1:0]           c_rd_addr_i,
  input  logic                    h_wr_en_i,
  input  logic [IW-1:0]           h_wr_addr_i,
  input  logic [lstm_pkg::QZ-1:0] h_wr_data_i,
  input  logic                    c_wr_en_i,
  input  logic [lstm_pkg::QZ-1:0] c_wr_data_i,
  output logic [lstm_pkg::QZ-1:0] h_prev_o,
  output logic [lstm_pkg::QZ-1:0] c_prev_o
);

  logic [lstm_pkg::QZ-1:0] h_mem [2][HIDDEN_SIZE];  // ping-pong hidden vector
  logic [lstm_pkg::QZ-1:0] c_mem [HIDDEN_SIZE];     // cell state, in place

  //////////////////////////////////////////////////////////////
  // reads from bank_sel, writes into the other bank
  assign h_prev_o = seq_first_i ? '0 : h_mem[bank_sel_i][h_rd_addr_i];
  assign c_prev_o = seq_first_i ? '0 : c_mem[c_rd_addr_i];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < HIDDEN_SIZE; i++)
      begin
        h_mem[0][i] <= '0;
        h_mem[1][i] <= '0;
        c_mem[i]    <= '0;
      end
    end
    else
    begin
      if (h_wr_en_i)
        h_mem[!bank_sel_i][h_wr_addr_i] <= h_wr_data_i;
      if (c_wr_en_i)
        c_mem[c_rd_addr_i] <= c_wr_data_i;  // shared address port
    end
  end

endmodule

`default_nettype wire

//--- hw/lstm_top.sv
`timescale 1ns/1ps
`default_nettype none

module lstm_top #(
  parameter  int INPUT_SIZE  = 4,
  parameter  int HIDDEN_SIZE = 4,
  parameter  int SEQ_LEN     = 3,
  localparam int IW          = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           start_i,
  input  logic                                           weight_valid_i,
  input  logic [lstm_pkg::GATE_NUM*lstm_pkg::QZ-1:0]     weight_i,
  input  logic [lstm_pkg::QZ-1:0]                        x_i,
  input  logic [lstm_pkg::GATE_NUM*lstm_pkg::BIAS_W-1:0] bias_i,
  output logic                                           x_read_o,
  output logic [lstm_pkg::QZ-1:0]                        h_o,
  output logic [IW-1:0]                                  h_index_o,
  output logic                                           h_valid_o,
  output logic                                           step_done_o
);

  lstm_pkg::phase_t                           phase;
  logic                                       beat_valid, first_beat, last_beat;
  logic [IW-1:0]                              h_rd_addr, unit_index, c_rd_addr;
  logic                                       bank_sel, seq_first;
  logic [lstm_pkg::QZ-1:0]                    h_prev, c_prev;
  logic [lstm_pkg::GATE_NUM*lstm_pkg::QZ-1:0] gates_pre;
  logic                                       gates_valid;
  logic                                       c_wr_en, h_wr_en;
  logic [lstm_pkg::QZ-1:0]                    c_wr_data, h_wr_data;
  logic [IW-1:0]                              h_wr_addr;

  //////////////////////////////////////////////////////////////
  lstm_seq_ctrl #(
    .INPUT_SIZE (INPUT_SIZE),
    .HIDDEN_SIZE(HIDDEN_SIZE),
    .SEQ_LEN    (SEQ_LEN)
  ) i_seq_ctrl (
    .clk, .rst_n, .start_i, .weight_valid_i,
    .h_wr_en_i   (h_wr_en),     .h_wr_addr_i (h_wr_addr),
    .phase_o     (phase),       .beat_valid_o(beat_valid),
    .first_beat_o(first_beat),  .last_beat_o (last_beat),
    .h_rd_addr_o (h_rd_addr),   .unit_index_o(unit_index),
    .bank_sel_o  (bank_sel),    .seq_first_o (seq_first),
    .x_read_o, .step_done_o
  );

  gate_mac i_gate_mac (
    .clk, .rst_n, .weight_i, .x_i, .bias_i,
    .phase_i      (phase),      .beat_valid_i (beat_valid),
    .first_beat_i (first_beat), .last_beat_i  (last_beat),
    .h_prev_i     (h_prev),
    .gates_pre_o  (gates_pre),  .gates_valid_o(gates_valid)
  );

  cell_update #(.HIDDEN_SIZE(HIDDEN_SIZE)) i_cell_update (
    .clk, .rst_n,
    .gates_pre_i (gates_pre),   .gates_valid_i(gates_valid),
    .unit_index_i(unit_index),  .c_prev_i     (c_prev),
    .c_rd_addr_o (c_rd_addr),   .c_wr_en_o    (c_wr_en),
    .c_wr_data_o (c_wr_data),   .h_wr_en_o    (h_wr_en),
    .h_wr_addr_o (h_wr_addr),   .h_wr_data_o  (h_wr_data),
    .h_o, .h_index_o, .h_valid_o
  );

  state_ram #(.HIDDEN_SIZE(HIDDEN_SIZE)) i_state_ram (
    .clk, .rst_n,
    .bank_sel_i (bank_sel),  .seq_first_i(seq_first),
    .h_rd_addr_i(h_rd_addr), .c_rd_addr_i(c_rd_addr),
    .h_wr_en_i  (h_wr_en),   .h_wr_addr_i(h_wr_addr), .h_wr_data_i(h_wr_data),
    .c_wr_en_i  (c_wr_en),   .c_wr_data_i(c_wr_data),
    .h_prev_o   (h_prev),    .c_prev_o   (c_prev)
  );

endmodule

`default_nettype wire

//--- verification/lstm_tb_model.svh
`ifndef LSTM_TB_MODEL_SVH
`define LSTM_TB_MODEL_SVH

logic [31:0] lfsr_state;

// x^32 + x^22 + x^2 + x + 1 stepped once per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int k = 0; k < n; k++)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    v          = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

function automatic logic [QZ-1:0] rand_q(input int shift);
  logic [31:0]          r;
  logic signed [QZ-1:0] v;
  r = rand_bits(QZ);
  v = r[QZ-1:0];
  return v >>> shift;                                        // smaller magnitude with sign kept
endfunction

function automatic longint sx(input logic [QZ-1:0] v);
  return longint'($signed(v));
endfunction

// Q.32 down to Q8.16 clamped to the 24-bit range
function automatic longint saturate_q(input longint acc);
  longint s;
  s = acc >>> lstm_pkg::QZ_D;
  if (s > 64'sd8388607)
    s = 64'sd8388607;
  else if (s < -64'sd8388608)
    s = -64'sd8388608;
  return s;
endfunction

function automatic longint sigmoid_pwl(input longint x);
  longint y;
  y = (x >>> 2) + 32768;                                     // x/4 + 0.5
  if (y < 0)
    y = 0;
  else if (y > 65536)
    y = 65536;
  return y;
endfunction

function automatic longint tanh_pwl(input longint x);
  if (x > 65536)
    return 65536;
  if (x < -65536)
    return -65536;
  return x;
endfunction

function automatic logic in_unit_range(input logic [QZ-1:0] v);
  return sx(v) >= -65536 && sx(v) <= 65536;
endfunction

task automatic build_table();
  longint      h_st [HIDDEN_SIZE];                          // h read bank
  longint      c_st [HIDDEN_SIZE];
  longint      h_nx [HIDDEN_SIZE];                          // h write bank
  longint      pre  [lstm_pkg::GATE_NUM];
  longint      acc;
  longint      opnd;
  longint      c_new;
  logic [31:0] rv;
  lfsr_state = 32'h406;                                      // seed
  row_shift  = '{8, 8, 8, 8, 1, 1, 8, 2, 8};                 // 8 gives about +-0.5
  row_gap    = '{0, 0, 0, 0, 0, 0, 3, 2, 3};
  for (int r = 0; r < NUM_ROWS; r++)
  begin
    for (int i = 0; i < INPUT_SIZE; i++)
      row_x[r][i] = rand_q(row_shift[r]);
    for (int u = 0; u < HIDDEN_SIZE; u++)
    begin
      for (int b = 0; b < BEATS; b++)
      begin
        for (int g = 0; g < lstm_pkg::GATE_NUM; g++)
          row_w[r][u][b][g*QZ +: QZ] = rand_q(row_shift[r]);
      end
      for (int g = 0; g < lstm_pkg::GATE_NUM; g++)
      begin
        rv                              = rand_bits(BIAS_W);
        row_b[r][u][g*BIAS_W +: BIAS_W] = rv[BIAS_W-1:0];
      end
    end
    if (r % SEQ_LEN == 0)
    begin
      for (int u = 0; u < HIDDEN_SIZE; u++)
      begin
        h_st[u] = 0;                                         // sequence boundary
        c_st[u] = 0;
      end
    end
    for (int u = 0; u < HIDDEN_SIZE; u++)
    begin
      for (int g = 0; g < lstm_pkg::GATE_NUM; g++)
      begin
        acc = longint'($signed(row_b[r][u][g*BIAS_W +: BIAS_W])) <<< lstm_pkg::QZ_D;
        for (int b = 0; b < BEATS; b++)
        begin
          if (b < INPUT_SIZE)
            opnd = sx(row_x[r][b]);
          else
            opnd = h_st[b - INPUT_SIZE];                     // previous step h
          acc += sx(row_w[r][u][b][g*QZ +: QZ]) * opnd;
        end
        pre[g] = saturate_q(acc);
      end
      c_new = saturate_q(sigmoid_pwl(pre[lstm_pkg::GATE_FORGET]) * c_st[u]
                       + sigmoid_pwl(pre[lstm_pkg::GATE_IN]) * tanh_pwl(pre[lstm_pkg::GATE_CELL]));
      c_st[u]     = c_new;
      h_nx[u]     = saturate_q(sigmoid_pwl(pre[lstm_pkg::GATE_OUT]) * tanh_pwl(c_new));
      row_h[r][u] = h_nx[u][QZ-1:0];
    end
    h_st = h_nx;                                             // bank swap
  end
endtask

`endif

//--- verification/lstm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lstm_tb;

  localparam int INPUT_SIZE     = 4;
  localparam int HIDDEN_SIZE    = 4;
  localparam int SEQ_LEN        = 3;
  localparam int IW             = (HIDDEN_SIZE > 1) ? $clog2(HIDDEN_SIZE) : 1;
  localparam int BEATS          = INPUT_SIZE + HIDDEN_SIZE;  // beats per unit
  localparam int NUM_ROWS       = 9;                         // three sequences
  localparam int MAX_GAP        = 3;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * HIDDEN_SIZE * (BEATS + MAX_GAP + 4) * 2
                                + RESET_CYCLES;
  localparam int QZ             = lstm_pkg::QZ;
  localparam int BIAS_W         = lstm_pkg::BIAS_W;
  localparam int WW             = lstm_pkg::GATE_NUM * QZ;
  localparam int BW             = lstm_pkg::GATE_NUM * BIAS_W;

  logic          clk;
  logic          rst_n;
  logic          start_i;
  logic          weight_valid_i;
  logic [WW-1:0] weight_i;
  logic [QZ-1:0] x_i;
  logic [BW-1:0] bias_i;
  logic          x_read_o;
  logic [QZ-1:0] h_o;
  logic [IW-1:0] h_index_o;
  logic          h_valid_o;
  logic          step_done_o;

  //////////////////////////////////////////////////////////////
  // stimulus table with one row per timestep
  int            row_shift [NUM_ROWS];                       // magnitude of w and x
  int            row_gap   [NUM_ROWS];                       // idle beats per unit
  logic [QZ-1:0] row_x     [NUM_ROWS][INPUT_SIZE];
  logic [WW-1:0] row_w     [NUM_ROWS][HIDDEN_SIZE][BEATS];
  logic [BW-1:0] row_b     [NUM_ROWS][HIDDEN_SIZE];
  logic [QZ-1:0] row_h     [NUM_ROWS][HIDDEN_SIZE];         // expected h

  int cycle_cnt;
  int cur_row;
  int h_seen;                                                // h outputs in this step
  int last_beat_cyc [HIDDEN_SIZE];

  lstm_top #(
    .INPUT_SIZE (INPUT_SIZE),
    .HIDDEN_SIZE(HIDDEN_SIZE),
    .SEQ_LEN    (SEQ_LEN)
  ) i_lstm_top (
    .clk, .rst_n, .start_i, .weight_valid_i, .weight_i, .x_i, .bias_i,
    .x_read_o, .h_o, .h_index_o, .h_valid_o, .step_done_o
  );

  always #5 clk = ~clk;                                      // 10 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // one clock of stimulus with x_read_o checked mid cycle
  task automatic drive_cycle(input logic valid, input logic [WW-1:0] w, input logic [QZ-1:0] x,
                             input logic [BW-1:0] b, input logic exp_read);
    @(posedge clk);
    #1;
    start_i        = 1'b0;
    weight_valid_i = valid;
    weight_i       = w;
    x_i            = x;
    bias_i         = b;
    @(negedge clk);
    check("x_read_o", x_read_o, exp_read);
  endtask

  task automatic run_row(input int r);
    int            gaps_left;
    logic [QZ-1:0] xv;
    cur_row = r;
    h_seen  = 0;
    @(posedge clk);
    #1;
    start_i = 1'b1;                                          // one-cycle pulse
    for (int u = 0; u < HIDDEN_SIZE; u++)
    begin
      gaps_left = row_gap[r];
      for (int b = 0; b < BEATS; b++)
      begin
        while (gaps_left > 0 && (rand_bits(1) == 1 || b == BEATS - 1))
        begin
          drive_cycle(1'b0, '0, '0, '0, 1'b0);               // hole in the stream
          gaps_left--;
        end
        if (b < INPUT_SIZE)
          xv = row_x[r][b];
        else
          xv = '0;
        drive_cycle(1'b1, row_w[r][u][b], xv, row_b[r][u], b < INPUT_SIZE);
      end
      last_beat_cyc[u] = cycle_cnt;
    end
    drive_cycle(1'b0, '0, '0, '0, 1'b0);
    while (!step_done_o)
      @(negedge clk);
    @(posedge clk);
    #1;
    check("h_valid_o count", h_seen, HIDDEN_SIZE);
  endtask

  //////////////////////////////////////////////////////////////
  // output monitor sampled on the falling edge
  always @(negedge clk)
  begin
    if (rst_n && h_valid_o)
    begin
      check("h_index_o", h_index_o, h_seen);
      check("h_o in unit range", in_unit_range(h_o), 1'b1);
      check("h_o", h_o, row_h[cur_row][h_seen]);
      check("h_valid_o latency", cycle_cnt, last_beat_cyc[h_seen] + 4);
      check("step_done_o", step_done_o, h_seen == HIDDEN_SIZE - 1);
      h_seen++;
    end
    else if (rst_n)
      check("step_done_o", step_done_o, 1'b0);               // only with the last h
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES)
      abort_run($sformatf("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES));
  end

  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    start_i        = 1'b0;
    weight_valid_i = 1'b0;
    weight_i       = '0;
    x_i            = '0;
    bias_i         = '0;
    cycle_cnt      = 0;
    cur_row        = 0;
    h_seen         = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (5)                                               // quiet before any start
    begin
      @(negedge clk);
      check("h_valid_o", h_valid_o, 1'b0);
      check("step_done_o", step_done_o, 1'b0);
      check("x_read_o", x_read_o, 1'b0);
    end
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    $display("Result: PASSED");
    $finish;
  end

  `include "lstm_tb_model.svh"

endmodule

`default_nettype wire

//--- all.f
+incdir+verification
hw/lstm_pkg.sv
hw/lstm_seq_ctrl.sv
hw/gate_mac.sv
hw/cell_update.sv
hw/state_ram.sv
hw/lstm_top.sv
verification/lstm_tb.sv

//--- Bender.yml
package:
  name: lstm_layer

sources:
  - hw/lstm_pkg.sv
  - hw/lstm_seq_ctrl.sv
  - hw/gate_mac.sv
  - hw/cell_update.sv
  - hw/state_ram.sv
  - hw/lstm_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/lstm_tb.sv
